//--- hdl/neoVideoPkg.sv
`default_nettype none

package neoVideoPkg;

	// Pixel path field widths
	localparam int COLOR_W = 4;
	localparam int SPR_PAL_W = 8;
	localparam int FIX_PAL_W = 4;
	localparam int LB_ADDR_W = 8;	// One index per even/odd pair
	localparam int LB_ENTRY_W = SPR_PAL_W + COLOR_W;
	localparam int PAL_ADDR_W = 12;

	// Color index within a palette
	typedef logic [COLOR_W-1:0] colorT;

	// Sprite palette from P bus bits 23..16
	typedef logic [SPR_PAL_W-1:0] sprPalT;

	// Fix palette from P bus bits 19..16
	typedef logic [FIX_PAL_W-1:0] fixPalT;

	// Pair index, pixel 2n even bank, 2n+1 odd bank
	typedef logic [LB_ADDR_W-1:0] lbAddrT;

	// Sprite palette above color
	typedef logic [LB_ENTRY_W-1:0] lbEntryT;

	// Palette RAM address
	typedef logic [PAL_ADDR_W-1:0] palAddrT;

	// Entries per bank
	localparam int LB_DEPTH = 256;

	// Transparent entry left behind read-out
	localparam lbEntryT LB_CLEAR = '1;

	// Blanking address
	localparam palAddrT PA_BLANK = '0;

endpackage

`default_nettype wire

//--- hdl/neoCpuPkg.sv
`default_nettype none

package neoCpuPkg;

	// CPU address bits 23..17
	localparam int CPU_ADDR_U_W = 7;

	typedef logic [CPU_ADDR_U_W-1:0] cpuAddrUT;

	// $30xxxx region, $300000 >> 17
	localparam cpuAddrUT WD_KICK_ADDR = 7'h18;

	// Cycles without a kick before reset
	localparam int WD_TIMEOUT_DEF = 65536;

	// Length of the nReset pulse
	localparam int WD_PULSE = 8;

	// Watchdog FSM
	typedef enum logic
	{
		wdCount,	// Waiting for kick or timeout
		wdReset		// Driving nReset low
	} wdStateT;

endpackage

`default_nettype wire

//--- hdl/lineBufferCounter.sv
`timescale 1ns/1ps
`default_nettype none

module lineBufferCounter
(
	input wire CLK_SPR_PAL,
	input wire arstN,
	input wire xLoad,						// Load sprite x position
	input wire neoVideoPkg::lbAddrT xPos,
	input wire wrStep,						// One pixel pair written
	input wire lineStart,					// Restart display read-out
	output neoVideoPkg::lbAddrT renderAddr,
	output neoVideoPkg::lbAddrT dispAddr,
	output logic dispOdd					// Display phase, 1 = odd pixel
);

	// Render side counter
	always_ff @(posedge CLK_SPR_PAL or negedge arstN)
	begin
		if (!arstN)
			renderAddr <= '0;
		else if (xLoad)
			renderAddr <= xPos;				// Place sprite
		else if (wrStep)
			renderAddr <= renderAddr + 1'b1;	// Next pair
	end

	// Display side, free running
	// Even then odd, index moves on after odd
	always_ff @(posedge CLK_SPR_PAL or negedge arstN)
	begin
		if (!arstN)
		begin
			dispAddr <= '0;
			dispOdd <= 1'b0;
		end
		else if (lineStart)
		begin
			dispAddr <= '0;
			dispOdd <= 1'b0;
		end
		else
		begin
			dispOdd <= ~dispOdd;
			if (dispOdd)
				dispAddr <= dispAddr + 1'b1;
		end
	end

	// Renderer never loads and steps at once
	assert property (@(posedge CLK_SPR_PAL) disable iff (!arstN)
		!(xLoad && wrStep))
		else $error("xLoad and wrStep in the same cycle");

endmodule

`default_nettype wire

//--- hdl/lineBufferBank.sv
`timescale 1ns/1ps
`default_nettype none

module lineBufferBank
(
	input wire CLK_SPR_PAL,
	input wire arstN,
	input wire render,							// 1 = render role, 0 = display role
	input wire neoVideoPkg::lbAddrT renderAddr,
	input wire wrStep,
	input wire weEven,
	input wire weOdd,
	input wire neoVideoPkg::colorT gad,			// Even pixel color
	input wire neoVideoPkg::colorT gbd,			// Odd pixel color
	input wire neoVideoPkg::sprPalT sprPal,
	input wire neoVideoPkg::lbAddrT dispAddr,
	input wire dispOdd,
	output neoVideoPkg::lbEntryT rdEntry		// One cycle after the slot
);

	import neoVideoPkg::*;

	lbEntryT evenMem [LB_DEPTH];
	lbEntryT oddMem [LB_DEPTH];

	logic sweepBusy;		// Post-reset clear running
	lbAddrT sweepAddr;
	logic clrPend;			// Clear behind last read
	logic clrOdd;
	lbAddrT clrAddr;

	// Sweep and clear-behind control
	always_ff @(posedge CLK_SPR_PAL or negedge arstN)
	begin
		if (!arstN)
		begin
			sweepBusy <= 1'b1;
			sweepAddr <= '0;
			clrPend <= 1'b0;
			clrOdd <= 1'b0;
			clrAddr <= '0;
		end
		else
		begin
			if (sweepBusy)
			begin
				sweepAddr <= sweepAddr + 1'b1;
				if (sweepAddr == lbAddrT'(LB_DEPTH - 1))
					sweepBusy <= 1'b0;		// Whole bank done
			end
			clrPend <= ~render && ~sweepBusy;	// Only the display bank clears
			clrOdd <= dispOdd;
			clrAddr <= dispAddr;
		end
	end

	// Both arrays, single write per array per cycle
	always_ff @(posedge CLK_SPR_PAL)
	begin
		if (sweepBusy)
		begin
			evenMem[sweepAddr] <= LB_CLEAR;
			oddMem[sweepAddr] <= LB_CLEAR;
		end
		else if (render)
		begin
			if (wrStep && weEven)
				evenMem[renderAddr] <= {sprPal, gad};
			if (wrStep && weOdd)
				oddMem[renderAddr] <= {sprPal, gbd};
		end
		else if (clrPend)
		begin
			if (clrOdd)
				oddMem[clrAddr] <= LB_CLEAR;
			else
				evenMem[clrAddr] <= LB_CLEAR;
		end
	end

	// Read side, transparent while sweeping
	always_ff @(posedge CLK_SPR_PAL or negedge arstN)
	begin
		if (!arstN)
			rdEntry <= LB_CLEAR;
		else if (sweepBusy)
			rdEntry <= LB_CLEAR;
		else
			rdEntry <= dispOdd ? oddMem[dispAddr] : evenMem[dispAddr];
	end

	// Renderer must wait out the sweep
	assert property (@(posedge CLK_SPR_PAL) disable iff (!arstN)
		sweepBusy |-> !(render && wrStep))
		else $error("Render write during clear sweep");

endmodule

`default_nettype wire

//--- hdl/fixPixelPipe.sv
`timescale 1ns/1ps
`default_nettype none

module fixPixelPipe
(
	input wire CLK_SPR_PAL,
	input wire arstN,
	input wire fixLoad,						// Shift A into B, capture A
	input wire [7:0] fixD,					// Two pixels interleaved
	input wire neoVideoPkg::fixPalT fixPalIn,
	input wire dispOdd,
	output neoVideoPkg::colorT fixColor,	// Aligned with line buffer read
	output neoVideoPkg::fixPalT fixPal
);

	import neoVideoPkg::*;

	logic [7:0] fixByteA;
	logic [7:0] fixByteB;
	fixPalT fixPalA;
	fixPalT fixPalB;

	// Two byte stages, zero means transparent
	always_ff @(posedge CLK_SPR_PAL or negedge arstN)
	begin
		if (!arstN)
		begin
			fixByteA <= '0;
			fixByteB <= '0;
			fixPalA <= '0;
			fixPalB <= '0;
		end
		else if (fixLoad)
		begin
			fixByteB <= fixByteA;
			fixPalB <= fixPalA;
			fixByteA <= fixD;
			fixPalA <= fixPalIn;
		end
	end

	// Nibble demux, one cycle late like the buffer
	always_ff @(posedge CLK_SPR_PAL or negedge arstN)
	begin
		if (!arstN)
		begin
			fixColor <= '0;
			fixPal <= '0;
		end
		else
		begin
			if (dispOdd)
				fixColor <= {fixByteB[7], fixByteB[5], fixByteB[3], fixByteB[1]};
			else
				fixColor <= {fixByteB[6], fixByteB[4], fixByteB[2], fixByteB[0]};
			fixPal <= fixPalB;
		end
	end

endmodule

`default_nettype wire

//--- hdl/paletteAddrMux.sv
`timescale 1ns/1ps
`default_nettype none

module paletteAddrMux
(
	input wire CLK_SPR_PAL,
	input wire arstN,
	input wire chbl,						// Blanking
	input wire neoVideoPkg::lbEntryT rdEntryA,
	input wire neoVideoPkg::lbEntryT rdEntryB,
	input wire bufFlip,						// 1 = bank A on display
	input wire neoVideoPkg::colorT fixColor,
	input wire neoVideoPkg::fixPalT fixPal,
	output neoVideoPkg::palAddrT pa
);

	import neoVideoPkg::*;

	logic chblD;			// Slot-aligned with rdEntry
	logic flipD;
	lbEntryT sprEntry;

	always_ff @(posedge CLK_SPR_PAL or negedge arstN)
	begin
		if (!arstN)
		begin
			chblD <= 1'b0;
			flipD <= 1'b0;
		end
		else
		begin
			chblD <= chbl;
			flipD <= bufFlip;
		end
	end

	// Display bank is the one not rendered to
	assign sprEntry = flipD ? rdEntryA : rdEntryB;

	// Blank, then opaque fix, then sprite
	always_ff @(posedge CLK_SPR_PAL or negedge arstN)
	begin
		if (!arstN)
			pa <= PA_BLANK;
		else if (chblD)
			pa <= PA_BLANK;
		else if (|fixColor)
			pa <= {4'h0, fixPal, fixColor};	// Fix palettes sit in 0..15
		else
			pa <= sprEntry;
	end

endmodule

`default_nettype wire

//--- hdl/watchdog.sv
`timescale 1ns/1ps
`default_nettype none

module watchdog
#(
	parameter int wdTimeout = neoCpuPkg::WD_TIMEOUT_DEF
)
(
	input wire CLK_SPR_PAL,
	input wire arstN,
	input wire nAs,
	input wire rw,							// 0 = write
	input wire nLds,
	input wire neoCpuPkg::cpuAddrUT cpuAddrU,
	output logic nReset
);

	import neoCpuPkg::*;

	localparam int CNT_W = $clog2(wdTimeout + 1);

	wdStateT state;
	logic [CNT_W-1:0] cnt;
	logic kick;

	// Byte write to $30xxxx, low byte lane
	assign kick = !nAs && !rw && !nLds && (cpuAddrU == WD_KICK_ADDR);

	always_ff @(posedge CLK_SPR_PAL or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= wdCount;
			cnt <= '0;
		end
		else
		begin
			case (state)
				wdCount:
				begin
					if (kick)
						cnt <= '0;				// Kicked in time
					else if (cnt == CNT_W'(wdTimeout - 1))
					begin
						state <= wdReset;		// Timed out
						cnt <= '0;
					end
					else
						cnt <= cnt + 1'b1;
				end
				wdReset:
				begin
					if (cnt == CNT_W'(WD_PULSE - 1))
					begin
						state <= wdCount;		// Restart watch
						cnt <= '0;
					end
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= wdCount;
			endcase
		end
	end

	assign nReset = (state != wdReset);

	// Pulse width as seen on the pin
	assert property (@(posedge CLK_SPR_PAL) disable iff (!arstN)
		$fell(nReset) |-> !nReset [*WD_PULSE] ##1 nReset)
		else $error("nReset pulse width wrong");

endmodule

`default_nettype wire

//--- hdl/neoB1.sv
`timescale 1ns/1ps
`default_nettype none

module neoB1
#(
	parameter int wdTimeout = neoCpuPkg::WD_TIMEOUT_DEF
)
(
	input wire CLK_SPR_PAL,					// Pixel clock
	input wire arstN,
	input wire [23:0] pBus,
	input wire palLoad,						// Sprite palette strobe
	input wire xLoad,
	input wire neoVideoPkg::lbAddrT xPos,
	input wire wrStep,
	input wire weEven,
	input wire weOdd,
	input wire neoVideoPkg::colorT gad,
	input wire neoVideoPkg::colorT gbd,
	input wire bufFlip,						// 0 = render into A
	input wire lineStart,
	input wire chbl,
	input wire fixLoad,
	input wire [7:0] fixD,
	input wire nAs,
	input wire rw,
	input wire nLds,
	input wire neoCpuPkg::cpuAddrUT cpuAddrU,
	output neoVideoPkg::palAddrT pa,
	output logic nReset
);

	import neoVideoPkg::*;

	sprPalT sprPal;
	lbAddrT renderAddr;
	lbAddrT dispAddr;
	logic dispOdd;
	lbEntryT rdEntryA;
	lbEntryT rdEntryB;
	colorT fixColor;
	fixPalT fixPal;

	// Sprite palette latch, only valid on P bus briefly
	always_ff @(posedge CLK_SPR_PAL or negedge arstN)
	begin
		if (!arstN)
			sprPal <= '0;
		else if (palLoad)
			sprPal <= pBus[23:16];
	end

	lineBufferCounter counters
	(
		.CLK_SPR_PAL(CLK_SPR_PAL),
		.arstN(arstN),
		.xLoad(xLoad),
		.xPos(xPos),
		.wrStep(wrStep),
		.lineStart(lineStart),
		.renderAddr(renderAddr),
		.dispAddr(dispAddr),
		.dispOdd(dispOdd)
	);

	// Ping-pong pair, roles swap on bufFlip
	lineBufferBank bankA
	(
		.CLK_SPR_PAL(CLK_SPR_PAL),
		.arstN(arstN),
		.render(~bufFlip),
		.renderAddr(renderAddr),
		.wrStep(wrStep),
		.weEven(weEven),
		.weOdd(weOdd),
		.gad(gad),
		.gbd(gbd),
		.sprPal(sprPal),
		.dispAddr(dispAddr),
		.dispOdd(dispOdd),
		.rdEntry(rdEntryA)
	);

	lineBufferBank bankB
	(
		.CLK_SPR_PAL(CLK_SPR_PAL),
		.arstN(arstN),
		.render(bufFlip),
		.renderAddr(renderAddr),
		.wrStep(wrStep),
		.weEven(weEven),
		.weOdd(weOdd),
		.gad(gad),
		.gbd(gbd),
		.sprPal(sprPal),
		.dispAddr(dispAddr),
		.dispOdd(dispOdd),
		.rdEntry(rdEntryB)
	);

	fixPixelPipe fixPipe
	(
		.CLK_SPR_PAL(CLK_SPR_PAL),
		.arstN(arstN),
		.fixLoad(fixLoad),
		.fixD(fixD),
		.fixPalIn(pBus[19:16]),				// Fix palette on P bus
		.dispOdd(dispOdd),
		.fixColor(fixColor),
		.fixPal(fixPal)
	);

	paletteAddrMux palMux
	(
		.CLK_SPR_PAL(CLK_SPR_PAL),
		.arstN(arstN),
		.chbl(chbl),
		.rdEntryA(rdEntryA),
		.rdEntryB(rdEntryB),
		.bufFlip(bufFlip),
		.fixColor(fixColor),
		.fixPal(fixPal),
		.pa(pa)
	);

	watchdog #(.wdTimeout(wdTimeout)) wd
	(
		.CLK_SPR_PAL(CLK_SPR_PAL),
		.arstN(arstN),
		.nAs(nAs),
		.rw(rw),
		.nLds(nLds),
		.cpuAddrU(cpuAddrU),
		.nReset(nReset)
	);

endmodule

`default_nettype wire

//--- bench/neoB1Tb.sv
`timescale 1ns/1ps
`default_nettype none

module neoB1Tb;

	import neoVideoPkg::*;
	import neoCpuPkg::*;

	localparam int CYCLE_LIMIT = 6000;	// Sweep, five read-outs, watchdog run
	localparam int LINE_PIX = 512;		// 256 pairs per line
	localparam int WD_CYCLES = 200;		// Shortened watchdog timeout
	localparam int WD_LOW = 8;			// Reset pulse length
	localparam cpuAddrUT KICK_UPPER = cpuAddrUT'(24'h300000 >> 17);

	logic CLK_SPR_PAL;
	logic arstN;
	logic [23:0] pBus;
	logic palLoad;
	logic xLoad;
	lbAddrT xPos;
	logic wrStep;
	logic weEven;
	logic weOdd;
	colorT gad;
	colorT gbd;
	logic bufFlip;
	logic lineStart;
	logic chbl;
	logic fixLoad;
	logic [7:0] fixD;
	logic nAs;
	logic rw;
	logic nLds;
	cpuAddrUT cpuAddrU;
	palAddrT pa;
	logic nReset;

	lbEntryT sprModel [LINE_PIX];	// Bank being rendered, by pixel
	logic [7:0] fixA;				// Fix stage models
	logic [7:0] fixB;
	fixPalT fixPalA;
	fixPalT fixPalB;
	int blankLo;					// chbl pixel range, upper bound excluded
	int blankHi;
	logic [31:0] rngState;
	int paErrors;
	int resetErrors;
	int cycles = 0;

	neoB1 #(.wdTimeout(WD_CYCLES)) dut
	(
		.CLK_SPR_PAL(CLK_SPR_PAL), .arstN(arstN), .pBus(pBus), .palLoad(palLoad),
		.xLoad(xLoad), .xPos(xPos), .wrStep(wrStep), .weEven(weEven), .weOdd(weOdd),
		.gad(gad), .gbd(gbd), .bufFlip(bufFlip), .lineStart(lineStart), .chbl(chbl),
		.fixLoad(fixLoad), .fixD(fixD), .nAs(nAs), .rw(rw), .nLds(nLds),
		.cpuAddrU(cpuAddrU), .pa(pa), .nReset(nReset)
	);

	initial
	begin
		CLK_SPR_PAL = 1'b0;
		forever #10 CLK_SPR_PAL = ~CLK_SPR_PAL;	// 20 ns pixel clock
	end

	// Hang guard
	always @(posedge CLK_SPR_PAL)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	task automatic checkPa(input string name, input palAddrT expected, input palAddrT actual);
		if (actual !== expected)
		begin
			paErrors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkReset(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			resetErrors++;
			$display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	// Cleared entry is all ones
	task automatic clearModel();
		for (int i = 0; i < LINE_PIX; i++)
			sprModel[i[8:0]] = '1;
	endtask

	// Priority rules applied to one display pixel
	function automatic palAddrT expectedPixel(input int k);
		colorT nib;
		if (k >= blankLo && k < blankHi)
			return '0;							// Blanked
		if (k[0])
			nib = {fixB[7], fixB[5], fixB[3], fixB[1]};
		else
			nib = {fixB[6], fixB[4], fixB[2], fixB[0]};
		if (nib != 4'h0)
			return {4'h0, fixPalB, nib};		// Opaque fix wins
		return sprModel[k[8:0]];
	endfunction

	// Random sprites into the render bank
	task automatic renderSprites(input int count);
		logic [31:0] r;
		sprPalT pal;
		lbAddrT addr;
		logic [8:0] idx;
		int pairs;
		for (int s = 0; s < count; s++)
		begin
			r = nextRandom();
			pal = r[7:0];
			addr = r[15:8];
			pairs = 4 + int'(r[18:16]);
			@(negedge CLK_SPR_PAL);
			palLoad = 1'b1;
			pBus = {pal, r[31:16]};
			xLoad = 1'b1;
			xPos = addr;
			@(negedge CLK_SPR_PAL);
			palLoad = 1'b0;
			xLoad = 1'b0;
			for (int p = 0; p < pairs; p++)
			begin
				r = nextRandom();
				wrStep = 1'b1;
				weEven = r[0];
				weOdd = r[1];
				gad = r[7:4];
				gbd = r[11:8];
				idx = {addr, 1'b0};				// Even pixel of the pair
				if (r[0])
					sprModel[idx] = {pal, r[7:4]};
				if (r[1])
					sprModel[idx + 9'd1] = {pal, r[11:8]};
				addr = addr + 1'b1;
				@(negedge CLK_SPR_PAL);
			end
			wrStep = 1'b0;
			weEven = 1'b0;
			weOdd = 1'b0;
		end
	endtask

	task automatic loadFix(input logic [7:0] b, input fixPalT p);
		@(negedge CLK_SPR_PAL);
		fixLoad = 1'b1;
		fixD = b;
		pBus = {4'h0, p, 16'h0};
		fixB = fixA;		// A moves on to B
		fixPalB = fixPalA;
		fixA = b;
		fixPalA = p;
		@(negedge CLK_SPR_PAL);
		fixLoad = 1'b0;
	endtask

	// One full line, pixel k seen k+2 cycles after lineStart
	task automatic readLine(input string name, input logic flip);
		for (int n = 0; n < LINE_PIX + 3; n++)
		begin
			@(negedge CLK_SPR_PAL);
			if (n >= 3)
				checkPa($sformatf("%s pixel %0d", name, n - 3), expectedPixel(n - 3), pa);
			lineStart = (n == 0);
			if (n == 1)
				bufFlip = flip;				// Swap roles at pixel 0 slot
			chbl = (n >= 1) && (n - 1 >= blankLo) && (n - 1 < blankHi);
		end
		chbl = 1'b0;
	endtask

	task automatic pulseKick();
		nAs = 1'b0;
		rw = 1'b0;
		nLds = 1'b0;
		cpuAddrU = KICK_UPPER;
		@(negedge CLK_SPR_PAL);
		nAs = 1'b1;
		rw = 1'b1;
		nLds = 1'b1;
		cpuAddrU = '0;
	endtask

	// Kick, then watch nReset for len cycles
	task automatic kickAndWatch(input string name, input int len, input int lowFrom,
		input int lowTo);
		pulseKick();
		for (int m = 1; m <= len; m++)
		begin
			if (m > 1)
				@(negedge CLK_SPR_PAL);
			checkReset($sformatf("%s cycle %0d", name, m), !(m >= lowFrom && m <= lowTo), nReset);
		end
	endtask

	task automatic watchdogTest();
		int guard;
		guard = 0;
		while (nReset !== 1'b1 && guard < 20)		// Let a running pulse end
		begin
			@(negedge CLK_SPR_PAL);
			guard++;
		end
		if (nReset !== 1'b1)
		begin
			resetErrors++;
			$display("Watchdog reset pulse never ended before the kick test");
		end
		for (int i = 0; i < 6; i++)
			kickAndWatch("wdKicked", 60, 0, 0);
		kickAndWatch("wdTimeout", WD_CYCLES + WD_LOW + 4, WD_CYCLES + 1, WD_CYCLES + WD_LOW);
	endtask

	initial
	begin
		arstN = 1'b0;
		pBus = '0;
		palLoad = 1'b0;
		xLoad = 1'b0;
		xPos = '0;
		wrStep = 1'b0;
		weEven = 1'b0;
		weOdd = 1'b0;
		gad = '0;
		gbd = '0;
		bufFlip = 1'b0;
		lineStart = 1'b0;
		chbl = 1'b0;
		fixLoad = 1'b0;
		fixD = '0;
		nAs = 1'b1;
		rw = 1'b1;
		nLds = 1'b1;
		cpuAddrU = '0;
		fixA = '0;
		fixB = '0;
		fixPalA = '0;
		fixPalB = '0;
		blankLo = 0;
		blankHi = 0;
		rngState = 32'h1ca25856;
		paErrors = 0;
		resetErrors = 0;
		clearModel();

		repeat (2) @(negedge CLK_SPR_PAL);
		arstN = 1'b1;
		checkPa("reset", '0, pa);
		checkReset("reset", 1'b1, nReset);
		repeat (260) @(negedge CLK_SPR_PAL);	// Clear sweep, 256 cycles

		readLine("clearAfterSweep", 1'b0);		// B on display

		clearModel();
		renderSprites(6);						// Into A
		readLine("spriteLine", 1'b1);

		clearModel();
		readLine("clearBehind", 1'b1);			// A again, now empty

		renderSprites(5);						// Into B
		loadFix(8'h14, 4'h9);					// Even nibble 6, odd nibble 0
		loadFix(8'(nextRandom() >> 24), 4'h3);	// Stays in stage A
		readLine("fixOverride", 1'b0);

		loadFix(8'h00, 4'h0);
		loadFix(8'h00, 4'h0);
		clearModel();
		renderSprites(6);						// Into A
		blankLo = 100;
		blankHi = 300;
		readLine("blank", 1'b1);
		blankLo = 0;
		blankHi = 0;

		watchdogTest();

		$display("Errors: pa %0d, nReset %0d, total %0d", paErrors, resetErrors,
			paErrors + resetErrors);
		if (paErrors + resetErrors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
hdl/neoVideoPkg.sv
hdl/neoCpuPkg.sv
hdl/lineBufferCounter.sv
hdl/lineBufferBank.sv
hdl/fixPixelPipe.sv
hdl/paletteAddrMux.sv
hdl/watchdog.sv
hdl/neoB1.sv
bench/neoB1Tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module neoB1Tb -f sim.f

output="$(./obj_dir/VneoB1Tb 2>&1 || true)"
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
	exit 0
else
	exit 1
fi
